// File: source/rv_params.svh
/*
 * RV32I core parameters
 * Widths, register count and the fetch address after reset
 */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data path and address width
`define XLEN 32

// Register file geometry
`define REG_ADDR_W 5
`define NUM_REGS 32

// Fetch
`define RESET_PC 32'h0000_0000
`define INSTR_BYTES 4   // PC step per instruction

`endif

// File: source/rv_pkg.sv
/*
 * RV32I core types
 * Major opcodes, ALU operations and forwarding selects
 */
package rv_pkg;

    // Major opcodes kept by the core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b  // lui
    } alu_op_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        fwd_reg = 2'b00,
        fwd_wb  = 2'b01,
        fwd_mem = 2'b10
    } fwd_sel_t;

endpackage

// File: source/fetch_stage.sv
/*
 * Fetch stage
 * Program counter and the IF/ID register
 */
`timescale 1ns/10ps
`include "rv_params.svh"

module fetch_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  logic              flush,
    input  logic              redirect,
    input  logic [`XLEN-1:0]  redirect_pc,
    output logic [`XLEN-1:0]  imem_addr,
    input  logic [`XLEN-1:0]  imem_data,
    output logic [`XLEN-1:0]  id_pc,
    output logic [`XLEN-1:0]  id_instr,
    output logic              id_valid
);

    logic [`XLEN-1:0] pc;

    assign imem_addr = pc;

    // Redirect wins over a load-use hold
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + `XLEN'(`INSTR_BYTES);
        end
    end

    // ====================
    // IF/ID register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (flush) begin
            id_valid <= 1'b0;       // Wrong-path fetch
        end else if (!stall) begin
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc    <= pc;
            id_instr <= imem_data;
        end
    end

endmodule

// File: source/decode_stage.sv
/*
 * Decode stage
 * Control decode, immediates, register file and the ID/EX register
 */
`timescale 1ns/10ps
`include "rv_params.svh"

module decode_stage import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic [`XLEN-1:0]       id_pc,
    input  logic [`XLEN-1:0]       id_instr,
    input  logic                   id_valid,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    input  logic [`XLEN-1:0]       wb_data,
    output logic                   ex_valid,
    output opcode_t                ex_op,
    output alu_op_t                ex_alu_op,
    output logic                   ex_use_imm,
    output logic [`REG_ADDR_W-1:0] ex_rs1,
    output logic [`REG_ADDR_W-1:0] ex_rs2,
    output logic [`REG_ADDR_W-1:0] ex_rd,
    output logic [`XLEN-1:0]       ex_rs1_data,
    output logic [`XLEN-1:0]       ex_rs2_data,
    output logic [`XLEN-1:0]       ex_imm,
    output logic [`XLEN-1:0]       ex_pc,
    output logic [2:0]             ex_funct3
);

    opcode_t                opcode;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [2:0]             funct3;
    logic                   funct7_alt;  // Selects sub and sra
    logic                   dec_known;
    alu_op_t                dec_alu_op;
    logic                   dec_use_imm;
    logic [`XLEN-1:0]       dec_imm;
    logic [`XLEN-1:0]       regs [`NUM_REGS];
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    assign opcode     = opcode_t'(id_instr[6:0]);
    assign rd         = id_instr[11:7];
    assign funct3     = id_instr[14:12];
    assign rs1        = id_instr[19:15];
    assign rs2        = id_instr[24:20];
    assign funct7_alt = id_instr[30];

    function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // ====================
    // Control and immediates
    always_comb begin
        dec_known   = 1'b1;
        dec_alu_op  = alu_add;
        dec_use_imm = 1'b1;
        dec_imm     = {{(`XLEN-12){id_instr[31]}}, id_instr[31:20]};  // I-type
        case (opcode)
            opc_op: begin
                dec_alu_op  = funct_to_alu(funct3, funct7_alt);
                dec_use_imm = 1'b0;
            end
            opc_op_imm: dec_alu_op = funct_to_alu(funct3, funct3 == 3'b101 && funct7_alt);
            opc_lui: begin
                dec_alu_op = alu_pass_b;
                dec_imm    = {id_instr[31:12], 12'b0};
            end
            opc_load: ;             // Address is rs1 + I-imm
            opc_store: dec_imm = {{(`XLEN-12){id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
            opc_branch: begin
                dec_alu_op  = alu_sub;
                dec_use_imm = 1'b0;
                dec_imm     = {{(`XLEN-12){id_instr[31]}}, id_instr[7], id_instr[30:25],
                               id_instr[11:8], 1'b0};
            end
            opc_jal: dec_imm = {{(`XLEN-20){id_instr[31]}}, id_instr[19:12], id_instr[20],
                                id_instr[30:21], 1'b0};
            default: dec_known = 1'b0;  // Becomes a bubble
        endcase
    end

    // ====================
    // Register file, x0 reads zero, writeback passes through
    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

    // ====================
    // ID/EX register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid && dec_known && !flush;
        end
    end

    always_ff @(posedge clk) begin
        ex_op       <= opcode;
        ex_alu_op   <= dec_alu_op;
        ex_use_imm  <= dec_use_imm;
        ex_rs1      <= rs1;
        ex_rs2      <= rs2;
        ex_rd       <= rd;
        ex_rs1_data <= rs1_data;
        ex_rs2_data <= rs2_data;
        ex_imm      <= dec_imm;
        ex_pc       <= id_pc;
        ex_funct3   <= funct3;
    end

endmodule

// File: source/hazard_unit.sv
/*
 * Hazard unit
 * Load-use stall, redirect flush and forwarding selects
 */
`timescale 1ns/10ps
`include "rv_params.svh"

module hazard_unit import rv_pkg::*; (
    input  logic [`REG_ADDR_W-1:0] id_rs1,
    input  logic [`REG_ADDR_W-1:0] id_rs2,
    input  logic                   ex_valid,
    input  opcode_t                ex_op,
    input  logic [`REG_ADDR_W-1:0] ex_rd,
    input  logic [`REG_ADDR_W-1:0] ex_rs1,
    input  logic [`REG_ADDR_W-1:0] ex_rs2,
    input  logic                   redirect,
    input  logic                   mem_en,
    input  logic [`REG_ADDR_W-1:0] mem_rd,
    input  logic                   wb_en,
    input  logic [`REG_ADDR_W-1:0] wb_rd,
    output logic                   stall,
    output logic                   flush,
    output fwd_sel_t               fwd_a,
    output fwd_sel_t               fwd_b
);

    logic load_use;

    // Load in execute feeding the instruction in decode
    assign load_use = ex_valid && ex_op == opc_load && ex_rd != '0 &&
                      (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign flush = redirect;
    assign stall = load_use && !redirect;   // Stalled instruction is wrong-path anyway

    // Memory stage is younger than writeback, so it wins
    function automatic fwd_sel_t pick_src(input logic [`REG_ADDR_W-1:0] rs);
        if (rs == '0)                  return fwd_reg;
        else if (mem_en && mem_rd == rs) return fwd_mem;
        else if (wb_en && wb_rd == rs)   return fwd_wb;
        else                             return fwd_reg;
    endfunction

    assign fwd_a = pick_src(ex_rs1);
    assign fwd_b = pick_src(ex_rs2);

endmodule

// File: source/execute_stage.sv
/*
 * Execute stage
 * Operand forwarding, ALU, branch resolution and the EX/MEM register
 */
`timescale 1ns/10ps
`include "rv_params.svh"

module execute_stage import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ex_valid,
    input  opcode_t                ex_op,
    input  alu_op_t                ex_alu_op,
    input  logic                   ex_use_imm,
    input  logic [`REG_ADDR_W-1:0] ex_rd,
    input  logic [`XLEN-1:0]       ex_rs1_data,
    input  logic [`XLEN-1:0]       ex_rs2_data,
    input  logic [`XLEN-1:0]       ex_imm,
    input  logic [`XLEN-1:0]       ex_pc,
    input  logic [2:0]             ex_funct3,
    input  fwd_sel_t               fwd_a,
    input  fwd_sel_t               fwd_b,
    input  logic [`XLEN-1:0]       wb_data,
    output logic                   redirect,
    output logic [`XLEN-1:0]       redirect_pc,
    output logic                   mem_en,
    output logic [`REG_ADDR_W-1:0] mem_rd,
    output logic [`XLEN-1:0]       mem_result,
    output logic [`XLEN-1:0]       mem_store_data,
    output logic                   mem_is_load,
    output logic                   mem_is_store,
    output logic                   mem_valid
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;     // Forwarded rs2, also the store data
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] result;
    logic [4:0]       shamt;
    logic             taken;
    logic             writes_rd;

    // ====================
    // Forwarding muxes
    assign op_a = (fwd_a == fwd_mem) ? mem_result :
                  (fwd_a == fwd_wb)  ? wb_data : ex_rs1_data;
    assign op_b = (fwd_b == fwd_mem) ? mem_result :
                  (fwd_b == fwd_wb)  ? wb_data : ex_rs2_data;

    assign alu_b = ex_use_imm ? ex_imm : op_b;
    assign shamt = alu_b[4:0];

    always_comb begin
        case (ex_alu_op)
            alu_add:  alu_out = op_a + alu_b;
            alu_sub:  alu_out = op_a - alu_b;
            alu_and:  alu_out = op_a & alu_b;
            alu_or:   alu_out = op_a | alu_b;
            alu_xor:  alu_out = op_a ^ alu_b;
            alu_slt:  alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            alu_sltu: alu_out = {{(`XLEN-1){1'b0}}, op_a < alu_b};
            alu_sll:  alu_out = op_a << shamt;
            alu_srl:  alu_out = op_a >> shamt;
            alu_sra:  alu_out = $unsigned($signed(op_a) >>> shamt);
            default:  alu_out = alu_b;      // pass_b
        endcase
    end

    // ====================
    // Branch compare on funct3
    always_comb begin
        case (ex_funct3)
            3'b000:  taken = (op_a == op_b);                    // beq
            3'b001:  taken = (op_a != op_b);                    // bne
            3'b100:  taken = ($signed(op_a) < $signed(op_b));   // blt
            3'b101:  taken = ($signed(op_a) >= $signed(op_b));  // bge
            default: taken = 1'b0;
        endcase
    end

    assign redirect    = ex_valid && (ex_op == opc_jal || (ex_op == opc_branch && taken));
    assign redirect_pc = ex_pc + ex_imm;

    // Link address replaces the ALU result for jal
    assign result    = (ex_op == opc_jal) ? ex_pc + `XLEN'(`INSTR_BYTES) : alu_out;
    assign writes_rd = ex_op inside {opc_op, opc_op_imm, opc_lui, opc_load, opc_jal};

    // ====================
    // EX/MEM register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_valid    <= 1'b0;
            mem_en       <= 1'b0;
            mem_is_load  <= 1'b0;
            mem_is_store <= 1'b0;
        end else begin
            mem_valid    <= ex_valid;
            mem_en       <= ex_valid && writes_rd && ex_rd != '0;
            mem_is_load  <= ex_valid && ex_op == opc_load;
            mem_is_store <= ex_valid && ex_op == opc_store;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd         <= ex_rd;
        mem_result     <= result;
        mem_store_data <= op_b;
    end

endmodule

// File: source/mem_wb_stage.sv
/*
 * Memory and writeback stages
 * Data port drive, MEM/WB register and writeback select
 */
`timescale 1ns/10ps
`include "rv_params.svh"

module mem_wb_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mem_en,
    input  logic [`REG_ADDR_W-1:0] mem_rd,
    input  logic [`XLEN-1:0]       mem_result,
    input  logic [`XLEN-1:0]       mem_store_data,
    input  logic                   mem_is_load,
    input  logic                   mem_is_store,
    input  logic                   mem_valid,
    input  logic [`XLEN-1:0]       dmem_rdata,
    output logic [`XLEN-1:0]       dmem_addr,
    output logic [`XLEN-1:0]       dmem_wdata,
    output logic                   dmem_req,
    output logic                   dmem_wr,
    output logic                   wb_en,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);

    logic [`XLEN-1:0] wb_sel;

    // ====================
    // Data port, word access only
    assign dmem_addr  = mem_result;
    assign dmem_wdata = mem_store_data;
    assign dmem_req   = mem_valid && (mem_is_load || mem_is_store);
    assign dmem_wr    = mem_valid && mem_is_store;

    // Memory answers in the same cycle
    assign wb_sel = mem_is_load ? dmem_rdata : mem_result;

    // ====================
    // MEM/WB register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= mem_valid && mem_en;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= wb_sel;
    end

endmodule

// File: source/rv_core.sv
/*
 * RV32I five-stage pipelined core
 * Stage and hazard unit wiring, separate instruction and data ports
 */
`timescale 1ns/10ps
`include "rv_params.svh"

module rv_core import rv_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    output logic [`XLEN-1:0]  imem_addr,
    input  logic [`XLEN-1:0]  imem_data,
    output logic [`XLEN-1:0]  dmem_addr,
    output logic [`XLEN-1:0]  dmem_wdata,
    input  logic [`XLEN-1:0]  dmem_rdata,
    output logic              dmem_req,
    output logic              dmem_wr
);

    logic stall, flush, redirect;
    logic [`XLEN-1:0] redirect_pc;
    fwd_sel_t fwd_a, fwd_b;

    // IF/ID
    logic [`XLEN-1:0] id_pc, id_instr;
    logic id_valid;

    // ID/EX
    logic ex_valid, ex_use_imm;
    opcode_t ex_op;
    alu_op_t ex_alu_op;
    logic [`REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
    logic [`XLEN-1:0] ex_rs1_data, ex_rs2_data, ex_imm, ex_pc;
    logic [2:0] ex_funct3;

    // EX/MEM and MEM/WB
    logic mem_en, mem_is_load, mem_is_store, mem_valid, wb_en;
    logic [`REG_ADDR_W-1:0] mem_rd, wb_rd;
    logic [`XLEN-1:0] mem_result, mem_store_data, wb_data;

    fetch_stage i_fetch (
        .clk(clk), .reset(reset), .stall(stall), .flush(flush),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .id_pc(id_pc), .id_instr(id_instr), .id_valid(id_valid)
    );

    // Load-use stall and redirect both put a bubble into ID/EX
    decode_stage i_decode (
        .clk(clk), .reset(reset), .flush(flush | stall),
        .id_pc(id_pc), .id_instr(id_instr), .id_valid(id_valid),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
        .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
        .ex_imm(ex_imm), .ex_pc(ex_pc), .ex_funct3(ex_funct3)
    );

    hazard_unit i_hazard (
        .id_rs1(id_instr[19:15]), .id_rs2(id_instr[24:20]),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_rd(ex_rd),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .redirect(redirect),
        .mem_en(mem_en), .mem_rd(mem_rd), .wb_en(wb_en), .wb_rd(wb_rd),
        .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    execute_stage i_execute (
        .clk(clk), .reset(reset),
        .ex_valid(ex_valid), .ex_op(ex_op), .ex_alu_op(ex_alu_op), .ex_use_imm(ex_use_imm),
        .ex_rd(ex_rd), .ex_rs1_data(ex_rs1_data), .ex_rs2_data(ex_rs2_data),
        .ex_imm(ex_imm), .ex_pc(ex_pc), .ex_funct3(ex_funct3),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .wb_data(wb_data),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .mem_en(mem_en), .mem_rd(mem_rd), .mem_result(mem_result),
        .mem_store_data(mem_store_data), .mem_is_load(mem_is_load),
        .mem_is_store(mem_is_store), .mem_valid(mem_valid)
    );

    mem_wb_stage i_mem_wb (
        .clk(clk), .reset(reset),
        .mem_en(mem_en), .mem_rd(mem_rd), .mem_result(mem_result),
        .mem_store_data(mem_store_data), .mem_is_load(mem_is_load),
        .mem_is_store(mem_is_store), .mem_valid(mem_valid), .dmem_rdata(dmem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_req(dmem_req),
        .dmem_wr(dmem_wr), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

// File: tb/rv_core_props.sv
/*
 * Data port properties of the RV32I core, bound into rv_core
 */
`timescale 1ns/10ps
`include "rv_params.svh"

module rv_core_props (
    input logic             clk,
    input logic             reset,
    input logic [`XLEN-1:0] dmem_addr,
    input logic             dmem_req,
    input logic             dmem_wr
);

    localparam logic [`XLEN-1:0] POISON_ADDR = 32'h0000_03fc;  // Only skipped code stores here

    // ====================
    // Strobe relations
    a_wr_needs_req: assert property (@(posedge clk) disable iff (reset) dmem_wr |-> dmem_req)
        else $error("Store strobe without a data request");

    a_word_aligned: assert property (@(posedge clk) disable iff (reset)
        dmem_req |-> dmem_addr[1:0] == 2'b00)
        else $error("Data address not word aligned");

    // No access while the core is held in reset
    a_idle_in_reset: assert property (@(posedge clk) reset |-> !dmem_req)
        else $error("Data request during reset");

    // ====================
    // Flushed instructions never reach memory
    a_no_poison: assert property (@(posedge clk) disable iff (reset)
        dmem_wr |-> dmem_addr != POISON_ADDR)
        else $error("Store to the poison address from a skipped instruction");

endmodule

bind rv_core rv_core_props i_props (
    .clk(clk), .reset(reset), .dmem_addr(dmem_addr), .dmem_req(dmem_req), .dmem_wr(dmem_wr)
);

// File: tb/rv_core_tb.sv
/*
 * Testbench for the RV32I core
 * Memory models, random program build, result and data port checks
 */
`timescale 1ns/10ps
`include "rv_params.svh"

module rv_core_tb import rv_pkg::*; ;

    localparam int MEM_WORDS        = 256;
    localparam int CYCLES_PER_INSTR = 20;
    localparam logic [31:0] LOAD_ADDR   = 32'h0000_0080;
    localparam logic [31:0] RESULT_BASE = 32'h0000_0100;
    localparam logic [31:0] DONE_ADDR   = 32'h0000_03f8;
    localparam logic [31:0] POISON_ADDR = 32'h0000_03fc;

    logic clk;
    logic reset;
    logic [31:0] imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
    logic dmem_req, dmem_wr;
    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];
    logic [31:0] lfsr = 32'h8c01_5c6c;
    logic [31:0] slot_addr = RESULT_BASE;
    logic [31:0] load_word;
    logic [31:0] exp_q [$];
    logic [31:0] addr_q [$];
    logic done = 1'b0;
    logic built = 1'b0;
    int prog_len = 0;
    int errors = 0;
    int checks = 0;
    int port_errors = 0;

    rv_core i_rv_core (
        .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
        .dmem_req(dmem_req), .dmem_wr(dmem_wr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Memory models
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_req ? dmem[dmem_addr[9:2]] : '0;  // Data only on a request

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                dmem[i] <= 32'h5a5a_0000 | 32'(i);   // Address-dependent fill
            end
            dmem[LOAD_ADDR[9:2]] <= load_word;
        end else if (dmem_wr) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
            if (dmem_addr == DONE_ADDR) done <= 1'b1;
        end
    end

    // ====================
    // Random constants and encoders
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    // ====================
    // Program assembly
    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic store_result(input logic [4:0] rs, input logic [31:0] expv);
        emit(enc_s(slot_addr[11:0], rs, 5'd0));
        addr_q.push_back(slot_addr);
        exp_q.push_back(expv);
        slot_addr = slot_addr + 32'd4;
    endtask

    task automatic alu_reg(input logic [2:0] f3, input logic alt, input logic [31:0] expv);
        emit(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd5));
        store_result(5'd5, expv);   // Store data comes from the memory stage
    endtask

    task automatic alu_imm(input logic [2:0] f3, input logic [11:0] imm, input logic [31:0] expv);
        emit(enc_i(imm, 5'd1, f3, 5'd5, opc_op_imm));
        store_result(5'd5, expv);
    endtask

    // Taken branches skip two poison stores, others fall into the tag store
    task automatic emit_branch(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic taken, input logic [11:0] tag);
        emit(enc_b(13'd12, rs2, rs1, f3));
        if (taken) begin
            emit(enc_s(POISON_ADDR[11:0], 5'd0, 5'd0));
            emit(enc_s(POISON_ADDR[11:0], 5'd0, 5'd0));
        end
        emit(enc_i(tag, 5'd0, 3'b000, 5'd9, opc_op_imm));
        store_result(5'd9, {20'b0, tag});
    endtask

    task automatic build_program();
        logic [31:0] ua, la, ub, lb, ic, a, b, ix, jal_pc;
        logic [4:0] sh;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = enc_i({1'b0, 11'(i)}, 5'd0, 3'b000, 5'd0, opc_op_imm);  // Tagged nops
        end
        take_bits(20, ua);
        take_bits(12, la);
        take_bits(20, ub);
        take_bits(12, lb);
        take_bits(12, ic);
        take_bits(32, load_word);
        a  = {ua[19:0], 12'b0} + {{20{la[11]}}, la[11:0]};
        b  = {ub[19:0], 12'b0} + {{20{lb[11]}}, lb[11:0]};
        ix = {{20{ic[11]}}, ic[11:0]};
        sh = ic[4:0];
        emit({ua[19:0], 5'd1, opc_lui});
        emit(enc_i(la[11:0], 5'd1, 3'b000, 5'd1, opc_op_imm));
        emit({ub[19:0], 5'd2, opc_lui});
        emit(enc_i(lb[11:0], 5'd2, 3'b000, 5'd2, opc_op_imm));
        alu_reg(3'b000, 1'b0, a + b);
        alu_reg(3'b000, 1'b1, a - b);
        alu_reg(3'b111, 1'b0, a & b);
        alu_reg(3'b110, 1'b0, a | b);
        alu_reg(3'b100, 1'b0, a ^ b);
        alu_reg(3'b010, 1'b0, {31'b0, $signed(a) < $signed(b)});
        alu_reg(3'b011, 1'b0, {31'b0, a < b});
        alu_reg(3'b001, 1'b0, a << b[4:0]);
        alu_reg(3'b101, 1'b0, a >> b[4:0]);
        alu_reg(3'b101, 1'b1, $unsigned($signed(a) >>> b[4:0]));
        alu_imm(3'b000, ic[11:0], a + ix);
        alu_imm(3'b111, ic[11:0], a & ix);
        alu_imm(3'b110, ic[11:0], a | ix);
        alu_imm(3'b100, ic[11:0], a ^ ix);
        alu_imm(3'b010, ic[11:0], {31'b0, $signed(a) < $signed(ix)});
        alu_imm(3'b011, ic[11:0], {31'b0, a < ix});
        alu_imm(3'b001, {7'h00, sh}, a << sh);
        alu_imm(3'b101, {7'h00, sh}, a >> sh);
        alu_imm(3'b101, {7'h20, sh}, $unsigned($signed(a) >>> sh));
        // Load followed at once by its user
        emit(enc_i(LOAD_ADDR[11:0], 5'd0, 3'b010, 5'd6, opc_load));
        emit(enc_r(7'h00, 5'd2, 5'd6, 3'b000, 5'd7));
        store_result(5'd7, load_word + b);
        emit_branch(3'b000, 5'd1, 5'd2, a == b, 12'd1);
        emit_branch(3'b001, 5'd1, 5'd2, a != b, 12'd2);
        emit_branch(3'b100, 5'd1, 5'd2, $signed(a) < $signed(b), 12'd3);
        emit_branch(3'b101, 5'd1, 5'd2, $signed(a) >= $signed(b), 12'd4);
        emit_branch(3'b000, 5'd1, 5'd1, 1'b1, 12'd5);   // Equal operands
        emit_branch(3'b001, 5'd1, 5'd1, 1'b0, 12'd6);
        emit_branch(3'b100, 5'd1, 5'd1, 1'b0, 12'd7);
        emit_branch(3'b101, 5'd1, 5'd1, 1'b1, 12'd8);
        jal_pc = 32'(prog_len * 4);
        emit(enc_j(21'd12, 5'd10));
        emit(enc_s(POISON_ADDR[11:0], 5'd0, 5'd0));
        emit(enc_s(POISON_ADDR[11:0], 5'd0, 5'd0));
        store_result(5'd10, jal_pc + 32'd4);
        emit(enc_i(12'h07b, 5'd0, 3'b000, 5'd0, opc_op_imm));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
        store_result(5'd0, 32'd0);
        emit(enc_s(DONE_ADDR[11:0], 5'd1, 5'd0));   // Final store ends the program
    endtask

    // ====================
    // Checks and end of run
    task automatic port_fail(input string msg);
        errors++;
        port_errors++;
        $display("Data port error at %0t: %s", $time, msg);
    endtask

    always @(negedge clk) begin
        if (reset) begin
            assert (!dmem_req) else port_fail("data request during reset");
        end else begin
            assert (!dmem_wr || dmem_req) else port_fail("store strobe without request");
            assert (!dmem_req || dmem_addr[1:0] == 2'b00)
                else port_fail("data address not word aligned");
            assert (!(dmem_wr && dmem_addr == POISON_ADDR))
                else port_fail("skipped instruction stored to the poison address");
        end
    end

    task automatic check_results();
        logic [31:0] got;
        for (int k = 0; k < exp_q.size(); k++) begin
            got = dmem[addr_q[k][9:2]];
            checks++;
            assert (got == exp_q[k]) else begin
                errors++;
                $display("FAILED at %0t: dmem[0x%h] expected 0x%h, actual 0x%h",
                         $time, addr_q[k], exp_q[k], got);
            end
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin
        reset = 1'b1;
        build_program();
        built = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
    end

    // Ends on the final store, or at once on a data port error
    initial begin
        wait (done || port_errors != 0);
        if (done) begin
            @(negedge clk);
            check_results();
        end else begin
            $display("Run stopped by a data port error before the final store");
        end
        finish_run();
    end

    // Watchdog
    initial begin
        wait (built);
        repeat (prog_len * CYCLES_PER_INSTR + 8) @(posedge clk);
        errors++;
        $display("Timeout: final store not seen after %0d cycles", prog_len * CYCLES_PER_INSTR);
        finish_run();
    end

endmodule

// File: sim.f
+incdir+source
source/rv_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/hazard_unit.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/rv_core.sv
tb/rv_core_props.sv
tb/rv_core_tb.sv

// File: Makefile
TOP = rv_core_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
